// ==== verilog/rp_analog_pkg.sv ====
// shared definitions for the analog core: bus structs, address map, cal defaults
// every bus access is a full 32-bit word, no byte selects
// offsets are byte addresses inside a 1 MB region, region field at addr[22:20]
`default_nettype none

package rp_analog_pkg;

  localparam int unsigned CHN = 2;  // ADC and DAC channel count

  ////////////////////
  // system bus
  ////////////////////

  typedef struct packed {
    logic [31:0] addr;   // byte address
    logic [31:0] wdata;  // full word only
    logic        wen;    // single cycle strobe
    logic        ren;    // single cycle strobe
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;  // valid with ack
    logic        err;    // valid with ack
    logic        ack;
  } sys_rsp_t;

  localparam sys_rsp_t SYS_RSP_IDLE = '0;  // no ack, no data

  localparam int unsigned REGION_BITS = 3;
  localparam int unsigned REGION_LSB  = 20;
  localparam int unsigned NUM_REGIONS = 2**REGION_BITS;

  localparam logic [REGION_BITS-1:0] HK_REGION = '0;  // housekeeping lives here

  typedef logic [REGION_LSB-1:0] ofs_t;  // offset inside a region

  ////////////////////
  // housekeeping map
  ////////////////////

  localparam ofs_t HK_ID    = 'h00;  // read only
  localparam ofs_t HK_LOOP  = 'h04;  // bit 0 digital loopback
  localparam ofs_t ADC_MUL0 = 'h10;
  localparam ofs_t ADC_MUL1 = 'h14;
  localparam ofs_t ADC_SUM0 = 'h18;
  localparam ofs_t ADC_SUM1 = 'h1C;
  localparam ofs_t DAC_MUL0 = 'h20;
  localparam ofs_t DAC_MUL1 = 'h24;
  localparam ofs_t DAC_SUM0 = 'h28;
  localparam ofs_t DAC_SUM1 = 'h2C;

  localparam logic [31:0] HK_ID_VALUE = 32'h5250_4131;

  // gain is fixed point with MUL_SHIFT fraction bits
  localparam int unsigned MUL_SHIFT  = 14;
  localparam int unsigned UNITY_GAIN = 2**MUL_SHIFT;  // 1.0

endpackage

`default_nettype wire

// ==== verilog/sys_bus_decoder.sv ====
// purely combinational, no clock and no state
// relies on one outstanding request at a time, idle slaves must answer all zero
// responses are OR-combined, so a late hk ack needs no stored region
`timescale 1ns/1ns
`default_nettype none

module sys_bus_decoder (
  input  rp_analog_pkg::sys_req_t sys_req_i,  // from bus master
  output rp_analog_pkg::sys_rsp_t sys_rsp_o,  // to bus master
  output rp_analog_pkg::sys_req_t hk_req_o,   // region 0 request
  input  rp_analog_pkg::sys_rsp_t hk_rsp_i    // region 0 response
);

  import rp_analog_pkg::*;

  logic [REGION_BITS-1:0] region;
  logic [NUM_REGIONS-1:0] cs;   // one-hot region select
  logic [NUM_REGIONS-1:0] wen;
  logic [NUM_REGIONS-1:0] ren;
  sys_rsp_t               rsp [NUM_REGIONS];

  ////////////////////
  // request side
  ////////////////////

  assign region = sys_req_i.addr[REGION_LSB +: REGION_BITS];
  assign cs     = NUM_REGIONS'(1) << region;

  assign wen = cs & {NUM_REGIONS{sys_req_i.wen}};  // gate strobes per region
  assign ren = cs & {NUM_REGIONS{sys_req_i.ren}};

  always_comb
  begin
    hk_req_o     = sys_req_i;       // addr and data shared
    hk_req_o.wen = wen[HK_REGION];
    hk_req_o.ren = ren[HK_REGION];
  end

  ////////////////////
  // response side
  ////////////////////

  for (genvar r = 0; r < NUM_REGIONS; r++)
  begin : g_region
    if (r == HK_REGION)
    begin : g_hk
      assign rsp[r] = hk_rsp_i;
    end
    else
    begin : g_empty
      // empty slave, ack in the request cycle
      assign rsp[r] = '{rdata: '0, err: 1'b0, ack: wen[r] | ren[r]};
    end
  end

  always_comb
  begin
    sys_rsp_o = SYS_RSP_IDLE;
    for (int r = 0; r < NUM_REGIONS; r++)
    begin
      sys_rsp_o = sys_rsp_o | rsp[r];  // only one slave answers per request
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hk_regs.sv ====
// housekeeping registers, acks exactly one cycle after each request
// gain and offset writes keep only the low DWM / DWS bits, reads sign extend
// rdata and err are zero whenever ack is low
`timescale 1ns/1ns
`default_nettype none

module hk_regs #(
  parameter int unsigned DWS = 14,  // sample width
  parameter int unsigned DWM = 16   // gain width
)(
  input  logic                                         adc_clk,
  input  logic                                         arst_n_i,
  input  rp_analog_pkg::sys_req_t                      hk_req_i,
  output rp_analog_pkg::sys_rsp_t                      hk_rsp_o,
  output logic                                         loop_o,     // digital loopback
  output logic signed [rp_analog_pkg::CHN-1:0][DWM-1:0] adc_mul_o, // ADC gain
  output logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] adc_sum_o, // ADC offset
  output logic signed [rp_analog_pkg::CHN-1:0][DWM-1:0] dac_mul_o, // DAC gain
  output logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] dac_sum_o  // DAC offset
);

  import rp_analog_pkg::*;

  ofs_t        ofs;
  logic        req;     // any access this cycle
  logic        hit;     // offset maps to a register
  logic [31:0] rd_val;

  assign ofs = hk_req_i.addr[REGION_LSB-1:0];
  assign req = hk_req_i.wen | hk_req_i.ren;

  ////////////////////
  // read decode
  ////////////////////

  always_comb
  begin
    hit    = 1'b1;
    rd_val = '0;
    case (ofs)
      HK_ID   : rd_val = HK_ID_VALUE;
      HK_LOOP : rd_val = {31'd0, loop_o};
      ADC_MUL0: rd_val = 32'($signed(adc_mul_o[0]));  // sign extend
      ADC_MUL1: rd_val = 32'($signed(adc_mul_o[1]));
      ADC_SUM0: rd_val = 32'($signed(adc_sum_o[0]));
      ADC_SUM1: rd_val = 32'($signed(adc_sum_o[1]));
      DAC_MUL0: rd_val = 32'($signed(dac_mul_o[0]));
      DAC_MUL1: rd_val = 32'($signed(dac_mul_o[1]));
      DAC_SUM0: rd_val = 32'($signed(dac_sum_o[0]));
      DAC_SUM1: rd_val = 32'($signed(dac_sum_o[1]));
      default : hit = 1'b0;  // unmapped, rdata stays 0
    endcase
  end

  ////////////////////
  // register writes
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_o    <= 1'b0;
      adc_mul_o <= {CHN{DWM'(UNITY_GAIN)}};  // gain 1.0
      adc_sum_o <= '0;
      dac_mul_o <= {CHN{DWM'(UNITY_GAIN)}};
      dac_sum_o <= '0;
    end
    else if (hk_req_i.wen)
    begin
      case (ofs)
        HK_LOOP : loop_o       <= hk_req_i.wdata[0];
        ADC_MUL0: adc_mul_o[0] <= hk_req_i.wdata[DWM-1:0];
        ADC_MUL1: adc_mul_o[1] <= hk_req_i.wdata[DWM-1:0];
        ADC_SUM0: adc_sum_o[0] <= hk_req_i.wdata[DWS-1:0];
        ADC_SUM1: adc_sum_o[1] <= hk_req_i.wdata[DWS-1:0];
        DAC_MUL0: dac_mul_o[0] <= hk_req_i.wdata[DWM-1:0];
        DAC_MUL1: dac_mul_o[1] <= hk_req_i.wdata[DWM-1:0];
        DAC_SUM0: dac_sum_o[0] <= hk_req_i.wdata[DWS-1:0];
        DAC_SUM1: dac_sum_o[1] <= hk_req_i.wdata[DWS-1:0];
        default : ;  // ID is read only, others flagged as err
      endcase
    end
  end

  // registered response, one cycle after req
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      hk_rsp_o <= SYS_RSP_IDLE;
    end
    else
    begin
      hk_rsp_o.ack   <= req;
      hk_rsp_o.err   <= req & ~hit;
      hk_rsp_o.rdata <= hk_req_i.ren ? rd_val : '0;  // writes return 0
    end
  end

endmodule

`default_nettype wire

// ==== verilog/linear_cal.sv ====
// one channel of gain and offset, two cycle latency, new sample every clock
// gain is fixed point with MUL_SHIFT fraction bits, shift rounds toward -inf
// assumes DWM > MUL_SHIFT so the scaled value is at least one bit wide
`timescale 1ns/1ns
`default_nettype none

module linear_cal #(
  parameter int unsigned DWS = 14,  // sample width
  parameter int unsigned DWM = 16   // gain width
)(
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  logic signed [DWS-1:0] dat_i,  // sample in
  input  logic signed [DWM-1:0] mul_i,  // gain
  input  logic signed [DWS-1:0] sum_i,  // offset
  output logic signed [DWS-1:0] dat_o   // calibrated sample
);

  import rp_analog_pkg::*;

  localparam int unsigned PW = DWS + DWM;     // full product
  localparam int unsigned SW = PW - MUL_SHIFT; // after scaling

  logic signed [PW-1:0]  mul_q;  // stage 1 product
  logic signed [SW-1:0]  shf;    // product >>> MUL_SHIFT
  logic signed [SW:0]    acc;    // one guard bit for the offset add
  logic                  ovf;
  logic signed [DWS-1:0] sat;

  ////////////////////
  // stage 1 multiply
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      mul_q <= '0;
    end
    else
    begin
      mul_q <= dat_i * mul_i;  // signed, full width
    end
  end

  ////////////////////
  // stage 2 scale, offset, clamp
  ////////////////////

  assign shf = mul_q[PW-1:MUL_SHIFT];  // drop fraction, floor
  assign acc = shf + sum_i;            // both sign extended

  // out of range unless all bits above the DWS sign bit agree
  assign ovf = ~(&acc[SW:DWS-1] | ~|acc[SW:DWS-1]);
  assign sat = ovf ? {acc[SW], {(DWS-1){~acc[SW]}}} : acc[DWS-1:0];

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dat_o <= '0;
    end
    else
    begin
      dat_o <= sat;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/adc_frontend.sv ====
// ADC pins arrive as negative slope offset binary, one word per channel
// pins to adc_dat_o is 3 cycles, loopback samples skip the input register
`timescale 1ns/1ns
`default_nettype none

module adc_frontend #(
  parameter int unsigned DWS = 14,
  parameter int unsigned DWM = 16
)(
  input  logic                                         adc_clk,
  input  logic                                         arst_n_i,
  input  logic        [rp_analog_pkg::CHN-1:0][DWS-1:0] adc_raw_i,  // pin codes
  input  logic                                         loop_i,     // use DAC samples
  input  logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] loop_dat_i, // calibrated DAC
  input  logic signed [rp_analog_pkg::CHN-1:0][DWM-1:0] mul_i,
  input  logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] sum_i,
  output logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] adc_dat_o
);

  import rp_analog_pkg::*;

  logic signed [CHN-1:0][DWS-1:0] raw_q;   // converted, two's complement
  logic signed [CHN-1:0][DWS-1:0] cal_in;  // after loopback select

  // input register, keep MSB and invert the rest
  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < CHN; ch++)
    begin
      raw_q[ch] <= {adc_raw_i[ch][DWS-1], ~adc_raw_i[ch][DWS-2:0]};
    end
  end

  assign cal_in = loop_i ? loop_dat_i : raw_q;  // digital loopback

  for (genvar ch = 0; ch < CHN; ch++)
  begin : g_cal
    linear_cal #(
      .DWS (DWS),
      .DWM (DWM)
    ) cal_i (
      .adc_clk  (adc_clk),
      .arst_n_i (arst_n_i),
      .dat_i    (cal_in[ch]),
      .mul_i    (mul_i[ch]),
      .sum_i    (sum_i[ch]),
      .dat_o    (adc_dat_o[ch])
    );
  end

endmodule

`default_nettype wire

// ==== verilog/dac_backend.sv ====
// sums two generator streams per channel, clamps, calibrates, converts
// dac_cal_o is 2 cycles after the generators, dac_dat_o 3 cycles
// dac_dat_o is negative slope code, same mapping as the ADC pins
`timescale 1ns/1ns
`default_nettype none

module dac_backend #(
  parameter int unsigned DWS = 14,
  parameter int unsigned DWM = 16
)(
  input  logic                                         adc_clk,
  input  logic                                         arst_n_i,
  input  logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] gen_a_i,
  input  logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] gen_b_i,
  input  logic signed [rp_analog_pkg::CHN-1:0][DWM-1:0] mul_i,
  input  logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] sum_i,
  output logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] dac_cal_o,  // to loopback
  output logic        [rp_analog_pkg::CHN-1:0][DWS-1:0] dac_dat_o   // to pins
);

  import rp_analog_pkg::*;

  logic signed [CHN-1:0][DWS:0]   gen_sum;  // one bit wider
  logic signed [CHN-1:0][DWS-1:0] gen_sat;

  ////////////////////
  // sum and clamp
  ////////////////////

  always_comb
  begin
    for (int ch = 0; ch < CHN; ch++)
    begin
      // element selects are unsigned, so re-sign before the add
      gen_sum[ch] = $signed(gen_a_i[ch]) + $signed(gen_b_i[ch]);
      gen_sat[ch] = (gen_sum[ch][DWS] ^ gen_sum[ch][DWS-1])  // top two disagree
                  ? {gen_sum[ch][DWS], {(DWS-1){~gen_sum[ch][DWS]}}}
                  : gen_sum[ch][DWS-1:0];
    end
  end

  for (genvar ch = 0; ch < CHN; ch++)
  begin : g_cal
    linear_cal #(
      .DWS (DWS),
      .DWM (DWM)
    ) cal_i (
      .adc_clk  (adc_clk),
      .arst_n_i (arst_n_i),
      .dat_i    (gen_sat[ch]),
      .mul_i    (mul_i[ch]),
      .sum_i    (sum_i[ch]),
      .dat_o    (dac_cal_o[ch])
    );
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_o <= '0;
    end
    else
    begin
      for (int ch = 0; ch < CHN; ch++)
      begin
        dac_dat_o[ch] <= {dac_cal_o[ch][DWS-1], ~dac_cal_o[ch][DWS-2:0]};  // back to neg slope
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/analog_top.sv ====
// analog core top, everything on adc_clk with async active low reset
// regions 1..7 of the bus answer as empty slaves
// generator streams come from outside, no back-pressure anywhere
`timescale 1ns/1ns
`default_nettype none

module analog_top #(
  parameter int unsigned DWS = 14,  // sample width
  parameter int unsigned DWM = 16   // gain width
)(
  input  logic                                         adc_clk,
  input  logic                                         arst_n_i,
  input  rp_analog_pkg::sys_req_t                      sys_req_i,
  output rp_analog_pkg::sys_rsp_t                      sys_rsp_o,
  input  logic        [rp_analog_pkg::CHN-1:0][DWS-1:0] adc_raw_i,  // ADC pins
  input  logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] gen_a_i,    // generator A
  input  logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] gen_b_i,    // generator B
  output logic signed [rp_analog_pkg::CHN-1:0][DWS-1:0] adc_dat_o,  // calibrated ADC
  output logic        [rp_analog_pkg::CHN-1:0][DWS-1:0] dac_dat_o   // DAC pins
);

  import rp_analog_pkg::*;

  sys_req_t                       hk_req;
  sys_rsp_t                       hk_rsp;
  logic                           loop;     // digital loopback enable
  logic signed [CHN-1:0][DWM-1:0] adc_mul;
  logic signed [CHN-1:0][DWS-1:0] adc_sum;
  logic signed [CHN-1:0][DWM-1:0] dac_mul;
  logic signed [CHN-1:0][DWS-1:0] dac_sum;
  logic signed [CHN-1:0][DWS-1:0] dac_cal;  // DAC path feeds ADC in loopback

  sys_bus_decoder dec_i (
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp)
  );

  hk_regs #(.DWS (DWS), .DWM (DWM)) hk_i (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .hk_req_i  (hk_req),
    .hk_rsp_o  (hk_rsp),
    .loop_o    (loop),
    .adc_mul_o (adc_mul),
    .adc_sum_o (adc_sum),
    .dac_mul_o (dac_mul),
    .dac_sum_o (dac_sum)
  );

  adc_frontend #(.DWS (DWS), .DWM (DWM)) adc_i (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .adc_raw_i  (adc_raw_i),
    .loop_i     (loop),
    .loop_dat_i (dac_cal),
    .mul_i      (adc_mul),
    .sum_i      (adc_sum),
    .adc_dat_o  (adc_dat_o)
  );

  dac_backend #(.DWS (DWS), .DWM (DWM)) dac_i (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .gen_a_i   (gen_a_i),
    .gen_b_i   (gen_b_i),
    .mul_i     (dac_mul),
    .sum_i     (dac_sum),
    .dac_cal_o (dac_cal),
    .dac_dat_o (dac_dat_o)
  );

endmodule

`default_nettype wire

// ==== bench/analog_sva.sv ====
// handshake checks on the housekeeping slave, bound into hk_regs
// ack exactly one cycle after each request and never without one
`timescale 1ns/1ns
`default_nettype none

module analog_sva (
  input logic                    adc_clk,
  input logic                    arst_n_i,
  input rp_analog_pkg::sys_req_t hk_req_i,
  input rp_analog_pkg::sys_rsp_t hk_rsp_o
);

  logic req;  // any access this cycle

  assign req = hk_req_i.wen | hk_req_i.ren;

  ack_after_req : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    req |=> hk_rsp_o.ack)
    else $error("hk ack missing one cycle after a request");

  no_stray_ack : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    hk_rsp_o.ack |-> $past(req))
    else $error("hk ack without a request in the cycle before");

  err_no_data : assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    hk_rsp_o.err |-> (hk_rsp_o.rdata == 32'd0))
    else $error("hk err with nonzero read data");

endmodule

bind hk_regs analog_sva sva_i (
  .adc_clk  (adc_clk),
  .arst_n_i (arst_n_i),
  .hk_req_i (hk_req_i),
  .hk_rsp_o (hk_rsp_o)
);

`default_nettype wire

// ==== bench/tb_analog.sv ====
// testbench for analog_top, vectors and expected values read from bench/analog_stim.txt
// run from the project root so the stimulus path resolves
// inputs change on the falling edge, outputs sampled on the falling edge
// sample checks come 3 cycles after a vector, 4 with loopback on
`timescale 1ns/1ns
`default_nettype none

module tb_analog;

  import rp_analog_pkg::*;

  localparam int    DWS           = 14;
  localparam int    DWM           = 16;
  localparam int    ACK_TIMEOUT   = 16;  // cycles per bus access
  localparam int    START_TIMEOUT = 32;  // cycles until the DAC shows idle code
  localparam string STIM_FILE     = "bench/analog_stim.txt";

  logic                           adc_clk;
  logic                           arst_n;
  sys_req_t                       sys_req;
  sys_rsp_t                       sys_rsp;
  logic        [CHN-1:0][DWS-1:0] adc_raw;  // pin codes
  logic signed [CHN-1:0][DWS-1:0] gen_a;
  logic signed [CHN-1:0][DWS-1:0] gen_b;
  logic signed [CHN-1:0][DWS-1:0] adc_dat;
  logic        [CHN-1:0][DWS-1:0] dac_dat;  // neg slope code

  logic loop_on;   // mirror of HK_LOOP bit 0
  int   fld [10];  // fields of the current stim line
  int   n_ops;     // stim lines run

  always #2 adc_clk = ~adc_clk;  // 4 ns period

  analog_top #(
    .DWS (DWS),
    .DWM (DWM)
  ) dut_i (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .adc_raw_i (adc_raw),
    .gen_a_i   (gen_a),
    .gen_b_i   (gen_b),
    .adc_dat_o (adc_dat),
    .dac_dat_o (dac_dat)
  );

  ////////////////////
  // helpers
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped after first error");
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      abort_run($sformatf("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  // one request cycle, then wait for ack, entered and left at a falling edge
  task automatic bus_access(
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        is_write,
    output sys_rsp_t    rsp
  );
    int waited;
    waited        = 0;
    rsp           = '0;
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = is_write;
    sys_req.ren   = ~is_write;
    while (!rsp.ack)
    begin
      @(negedge adc_clk);
      rsp     = sys_rsp;  // sample before the request drops
      sys_req = '0;       // strobe lasts one cycle
      waited++;
      if (!rsp.ack && waited > ACK_TIMEOUT)
        abort_run($sformatf("no bus ack within %0d cycles at address %h", ACK_TIMEOUT, addr));
    end
  endtask

  // apply one vector and hold it until the check
  task automatic run_sample();
    int lat;
    int ch;
    lat = loop_on ? 4 : 3;  // loopback adds the DAC cal, skips the input reg
    for (ch = 0; ch < CHN; ch++)
    begin
      adc_raw[ch] = fld[ch][DWS-1:0];
      gen_a[ch]   = fld[2+ch][DWS-1:0];
      gen_b[ch]   = fld[4+ch][DWS-1:0];
    end
    repeat (lat) @(posedge adc_clk);
    @(negedge adc_clk);
    for (ch = 0; ch < CHN; ch++)
    begin
      check_equal(32'(adc_dat[ch]), 32'(fld[6+ch][DWS-1:0]), $sformatf("adc_dat_o ch%0d", ch));
      check_equal(32'(dac_dat[ch]), 32'(fld[8+ch][DWS-1:0]), $sformatf("dac_dat_o ch%0d", ch));
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    int               fd;
    int               n;
    int               ch;
    int               waited;
    logic [7:0]       kind;      // first char of a stim line
    logic [8*128-1:0] skip_buf;  // rest of a comment line
    sys_rsp_t         rsp;

    adc_clk = 1'b0;
    arst_n  = 1'b0;
    sys_req = '0;
    adc_raw = {CHN{14'h1fff}};  // pin code for zero
    gen_a   = '0;
    gen_b   = '0;
    loop_on = 1'b0;
    n_ops   = 0;

    // reset state, sampled while reset is still low
    repeat (15) @(negedge adc_clk);
    check_equal(32'(sys_rsp.ack), 32'd0, "ack in reset");
    check_equal(32'(sys_rsp.err), 32'd0, "err in reset");
    for (ch = 0; ch < CHN; ch++)
    begin
      check_equal(32'(adc_dat[ch]), 32'd0, "adc_dat_o in reset");
      check_equal(32'(dac_dat[ch]), 32'd0, "dac_dat_o in reset");
    end
    @(negedge adc_clk);
    arst_n = 1'b1;  // after 16 cycles

    // zero generators must reach the pins as idle code
    waited = 0;
    while (dac_dat !== {CHN{14'h1fff}})
    begin
      @(negedge adc_clk);
      waited++;
      if (waited > START_TIMEOUT)
        abort_run("DAC output never reached idle code after reset");
    end

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
      abort_run("cannot open bench/analog_stim.txt, run from the project root");
    while (!$feof(fd))
    begin
      n = $fscanf(fd, " %c", kind);
      if (n == 1)
      begin
        case (kind)
          "#":
            void'($fgets(skip_buf, fd));
          "W":
          begin
            n = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
            if (n != 3)
              abort_run("malformed write line in stimulus file");
            bus_access(fld[0], fld[1], 1'b1, rsp);
            check_equal(32'(rsp.err), fld[2], $sformatf("write err at %h", fld[0]));
            if (fld[0] == 32'h4 && !rsp.err)
              loop_on = fld[1][0];  // latency follows the loop bit
            n_ops++;
          end
          "R":
          begin
            n = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
            if (n != 3)
              abort_run("malformed read line in stimulus file");
            bus_access(fld[0], 32'd0, 1'b0, rsp);
            check_equal(rsp.rdata, fld[1], $sformatf("read data at %h", fld[0]));
            check_equal(32'(rsp.err), fld[2], $sformatf("read err at %h", fld[0]));
            n_ops++;
          end
          "S":
          begin
            n = $fscanf(fd, "%h %h %d %d %d %d %d %d %h %h", fld[0], fld[1], fld[2],
                        fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9]);
            if (n != 10)
              abort_run("malformed sample line in stimulus file");
            run_sample();
            n_ops++;
          end
          default:
            abort_run("unknown line kind in stimulus file");
        endcase
      end
    end
    $fclose(fd);

    if (n_ops == 0)
      abort_run("stimulus file held no transactions");
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== bench/analog_stim.txt ====
# W addr wdata err / R addr rdata err, bus fields in hex
# S raw0 raw1 gena0 gena1 genb0 genb1 adc0 adc1 dac0 dac1, raw and dac codes in hex
R 00000000 52504131 0
R 00000004 00000000 0
R 00000010 00004000 0
R 0000001c 00000000 0
S 1000 3fff 0 0 0 0 4095 -8192 1fff 1fff
W 00000010 00002000 0
W 00000014 00006000 0
W 00000018 00000064 0
W 0000001c ffffffce 0
R 0000001c ffffffce 0
S 1000 3000 0 0 0 0 2147 -6196 1fff 1fff
S 3fff 0000 0 0 0 0 -3996 8191 1fff 1fff
S 0000 3fff 0 0 0 0 4195 -8192 1fff 1fff
S 1fff 1fff 5000 -5000 4000 -4000 100 -50 0000 3fff
W 00000020 00002000 0
W 00000024 00006000 0
W 00000028 0000000a 0
W 0000002c ffffffec 0
S 1fff 1fff 1000 -3000 234 -1001 100 -50 1d8c 3785
S 1fff 1fff 8000 -8000 8000 -8000 100 -50 0ff6 3fff
W 00000004 00000001 0
R 00000004 00000001 0
S 0000 0000 1000 -3000 234 -1001 413 -8192 1d8c 3785
S 0000 0000 -2000 2000 0 0 -395 4420 23dd 145b
W 00000004 00000000 0
R 00300000 00000000 0
W 00500004 12345678 0
W 00000030 00001111 1
R 00000030 00000000 1
R 0000002c ffffffec 0

// ==== tb.f ====
verilog/rp_analog_pkg.sv
verilog/sys_bus_decoder.sv
verilog/hk_regs.sv
verilog/linear_cal.sv
verilog/adc_frontend.sv
verilog/dac_backend.sv
verilog/analog_top.sv
bench/analog_sva.sv
bench/tb_analog.sv

// ==== Makefile ====
# Verilator build and run of the analog core testbench
VERILATOR ?= verilator
TOP       ?= tb_analog
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
